/* alu_pkg.sv */
package alu_pkg;

    localparam int XLEN      = 32;
    localparam int SHAMT_W   = 5;
    localparam int DECINST_W = 12;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [SHAMT_W-1:0]   shamt_t;
    typedef logic [DECINST_W-1:0] decinst_t;
    typedef logic [4:0]           fn_t;

    localparam shamt_t BIG_STEP = 5'd4;    // coarse shift step

    // decoded-instruction codes
    localparam decinst_t DI_ADDI  = 12'b000000010011;
    localparam decinst_t DI_ADD   = 12'b000000110011;
    localparam decinst_t DI_SUB   = 12'b100000110011;
    localparam decinst_t DI_ANDI  = 12'b001110010011;
    localparam decinst_t DI_AND   = 12'b001110110011;
    localparam decinst_t DI_XORI  = 12'b001000010011;
    localparam decinst_t DI_XOR   = 12'b001000110011;
    localparam decinst_t DI_ORI   = 12'b001100010011;
    localparam decinst_t DI_OR    = 12'b001100110011;
    localparam decinst_t DI_SLTI  = 12'b000100010011;
    localparam decinst_t DI_SLTIU = 12'b000110010011;
    localparam decinst_t DI_SLT   = 12'b000100110011;
    localparam decinst_t DI_SLTU  = 12'b000110110011;
    localparam decinst_t DI_BEQ   = 12'b000001100011;
    localparam decinst_t DI_BNE   = 12'b000011100011;
    localparam decinst_t DI_BLT   = 12'b001001100011;
    localparam decinst_t DI_BGE   = 12'b001011100011;
    localparam decinst_t DI_BLTU  = 12'b001101100011;
    localparam decinst_t DI_BGEU  = 12'b001111100011;
    localparam decinst_t DI_SRL   = 12'b001010110011;
    localparam decinst_t DI_SRLI  = 12'b001010010011;
    localparam decinst_t DI_SLL   = 12'b000010110011;
    localparam decinst_t DI_SLLI  = 12'b000010010011;
    localparam decinst_t DI_SRA   = 12'b101010110011;
    localparam decinst_t DI_SRAI  = 12'b011010010011;

    // internal function codes
    localparam fn_t FN_NONE = 5'd0;
    localparam fn_t FN_ADD  = 5'd1;
    localparam fn_t FN_SUB  = 5'd2;
    localparam fn_t FN_AND  = 5'd3;
    localparam fn_t FN_XOR  = 5'd4;
    localparam fn_t FN_OR   = 5'd5;
    localparam fn_t FN_SLT  = 5'd6;
    localparam fn_t FN_SLTU = 5'd7;
    localparam fn_t FN_BEQ  = 5'd8;
    localparam fn_t FN_BNE  = 5'd9;
    localparam fn_t FN_BLT  = 5'd10;
    localparam fn_t FN_BGE  = 5'd11;
    localparam fn_t FN_BLTU = 5'd12;
    localparam fn_t FN_BGEU = 5'd13;
    localparam fn_t FN_SRL  = 5'd14;
    localparam fn_t FN_SLL  = 5'd15;
    localparam fn_t FN_SRA  = 5'd16;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_HOLD
    } alu_state_t;

endpackage

/* alu_issue_if.sv */
`timescale 1ns/10ps

interface alu_issue_if;
    import alu_pkg::*;

    word_t rs1;
    word_t oper2;      // rs2 or imm, already selected
    fn_t   fn;
    logic  is_shift;

    modport src (
        output rs1, oper2, fn, is_shift
    );

    modport dst (
        input rs1, oper2, fn, is_shift
    );

endinterface

/* shift_step_if.sv */
`timescale 1ns/10ps

interface shift_step_if;
    logic load;        // capture strobe on accept
    logic shift_en;
    logic step_big;    // count >= 4
    logic done;        // count == 0

    modport ctrl (
        output load, shift_en,
        input  done
    );

    modport cnt (
        input  load, shift_en,
        output step_big, done
    );

    modport sh (
        input load, shift_en, step_big
    );

endinterface

/* alu_issue.sv */
`timescale 1ns/10ps

module alu_issue (
    input  alu_pkg::decinst_t decinst,
    input  alu_pkg::word_t    rs1,
    input  alu_pkg::word_t    rs2,
    input  alu_pkg::word_t    imm,
    alu_issue_if.src          iss
);
    import alu_pkg::*;

    logic use_imm;

    always_comb begin
        iss.fn       = FN_NONE;
        iss.is_shift = 1'b0;
        use_imm      = 1'b0;
        case (decinst)
            DI_ADDI:  begin iss.fn = FN_ADD;  use_imm = 1'b1; end
            DI_ADD:   iss.fn = FN_ADD;
            DI_SUB:   iss.fn = FN_SUB;
            DI_ANDI:  begin iss.fn = FN_AND;  use_imm = 1'b1; end
            DI_AND:   iss.fn = FN_AND;
            DI_XORI:  begin iss.fn = FN_XOR;  use_imm = 1'b1; end
            DI_XOR:   iss.fn = FN_XOR;
            DI_ORI:   begin iss.fn = FN_OR;   use_imm = 1'b1; end
            DI_OR:    iss.fn = FN_OR;
            DI_SLTI:  begin iss.fn = FN_SLT;  use_imm = 1'b1; end
            DI_SLTIU: begin iss.fn = FN_SLTU; use_imm = 1'b1; end
            DI_SLT:   iss.fn = FN_SLT;
            DI_SLTU:  iss.fn = FN_SLTU;
            DI_BEQ:   iss.fn = FN_BEQ;
            DI_BNE:   iss.fn = FN_BNE;
            DI_BLT:   iss.fn = FN_BLT;
            DI_BGE:   iss.fn = FN_BGE;
            DI_BLTU:  iss.fn = FN_BLTU;
            DI_BGEU:  iss.fn = FN_BGEU;
            DI_SRL: begin
                iss.fn       = FN_SRL;
                iss.is_shift = 1'b1;
            end
            DI_SRLI: begin
                iss.fn       = FN_SRL;
                iss.is_shift = 1'b1;
                use_imm      = 1'b1;
            end
            DI_SLL: begin
                iss.fn       = FN_SLL;
                iss.is_shift = 1'b1;
            end
            DI_SLLI: begin
                iss.fn       = FN_SLL;
                iss.is_shift = 1'b1;
                use_imm      = 1'b1;
            end
            DI_SRA: begin
                iss.fn       = FN_SRA;
                iss.is_shift = 1'b1;
            end
            DI_SRAI: begin
                iss.fn       = FN_SRA;
                iss.is_shift = 1'b1;
                use_imm      = 1'b1;
            end
            default: ;    // unknown code stays FN_NONE
        endcase
    end

    assign iss.oper2 = use_imm ? imm : rs2;
    assign iss.rs1   = rs1;

endmodule

/* alu_ctrl_fsm.sv */
`timescale 1ns/10ps

module alu_ctrl_fsm (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    output logic         in_ready,
    output logic         out_valid,
    input  logic         out_ready,
    alu_issue_if.dst     iss,
    shift_step_if.ctrl   step,
    output logic         load
);
    import alu_pkg::*;

    alu_state_t state;
    alu_state_t state_next;

    assign in_ready  = (state == S_IDLE);
    assign out_valid = (state == S_HOLD);
    assign load      = in_valid & in_ready;    // accept edge
    assign step.load = load;

    always_comb begin
        state_next    = state;
        step.shift_en = 1'b0;
        case (state)
            S_IDLE: begin
                if (load) begin
                    state_next = iss.is_shift ? S_SHIFT : S_HOLD;
                end
            end
            S_SHIFT: begin
                if (step.done) begin
                    state_next = S_HOLD;
                end else begin
                    step.shift_en = 1'b1;    // one step of 4 or 1
                end
            end
            S_HOLD: begin
                if (out_ready) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* shift_counter.sv */
`timescale 1ns/10ps

module shift_counter (
    input  logic        clk,
    input  logic        reset,
    alu_issue_if.dst    iss,
    shift_step_if.cnt   step
);
    import alu_pkg::*;

    shamt_t count;

    always_ff @(posedge clk) begin
        if (!reset) begin
            count <= '0;
        end else if (step.load) begin
            count <= iss.oper2[SHAMT_W-1:0];    // low bits only
        end else if (step.shift_en) begin
            if (step.step_big) begin
                count <= count - BIG_STEP;
            end else begin
                count <= count - shamt_t'(1);
            end
        end
    end

    assign step.step_big = (count >= BIG_STEP);
    assign step.done     = (count == '0);

endmodule

/* alu_shifter.sv */
`timescale 1ns/10ps

module alu_shifter (
    input  logic           clk,
    input  logic           reset,
    alu_issue_if.dst       iss,
    shift_step_if.sh       step,
    output alu_pkg::word_t shift_result
);
    import alu_pkg::*;

    word_t  sh_data;
    fn_t    sh_kind;    // FN_SRL, FN_SLL or FN_SRA
    shamt_t step_amt;

    assign step_amt = step.step_big ? BIG_STEP : shamt_t'(1);

    always_ff @(posedge clk) begin
        if (!reset) begin
            sh_kind <= FN_NONE;
        end else if (step.load) begin
            sh_kind <= iss.fn;
        end
    end

    always_ff @(posedge clk) begin
        if (step.load) begin
            sh_data <= iss.rs1;
        end else if (step.shift_en) begin
            case (sh_kind)
                FN_SLL:  sh_data <= sh_data << step_amt;
                FN_SRA:  sh_data <= word_t'($signed(sh_data) >>> step_amt);    // sign fill
                default: sh_data <= sh_data >> step_amt;
            endcase
        end
    end

    assign shift_result = sh_data;

endmodule

/* alu_compute.sv */
`timescale 1ns/10ps

module alu_compute (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    alu_issue_if.dst       iss,
    input  alu_pkg::word_t shift_result,
    output alu_pkg::word_t rd,
    output logic           is_rd,
    output logic           cmp
);
    import alu_pkg::*;

    word_t rs1_q;
    word_t oper2_q;
    fn_t   fn_q;
    logic  eq;
    logic  lt_s;
    logic  lt_u;

    always_ff @(posedge clk) begin
        if (!reset) begin
            fn_q <= FN_NONE;
        end else if (load) begin
            fn_q <= iss.fn;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rs1_q   <= iss.rs1;
            oper2_q <= iss.oper2;
        end
    end

    assign eq   = (rs1_q == oper2_q);
    assign lt_s = ($signed(rs1_q) < $signed(oper2_q));
    assign lt_u = (rs1_q < oper2_q);    // shared by sltu and bltu

    always_comb begin
        rd    = '0;
        is_rd = 1'b1;
        cmp   = 1'b0;
        case (fn_q)
            FN_ADD:  rd = rs1_q + oper2_q;
            FN_SUB:  rd = rs1_q - oper2_q;
            FN_AND:  rd = rs1_q & oper2_q;
            FN_XOR:  rd = rs1_q ^ oper2_q;
            FN_OR:   rd = rs1_q | oper2_q;
            FN_SLT:  rd = word_t'(lt_s);
            FN_SLTU: rd = word_t'(lt_u);
            FN_SRL, FN_SLL, FN_SRA: rd = shift_result;
            FN_BEQ:  begin is_rd = 1'b0; cmp = eq;    end
            FN_BNE:  begin is_rd = 1'b0; cmp = !eq;   end
            FN_BLT:  begin is_rd = 1'b0; cmp = lt_s;  end
            FN_BGE:  begin is_rd = 1'b0; cmp = !lt_s; end
            FN_BLTU: begin is_rd = 1'b0; cmp = lt_u;  end
            FN_BGEU: begin is_rd = 1'b0; cmp = !lt_u; end
            default: is_rd = 1'b0;    // unknown code writes nothing
        endcase
    end

endmodule

/* alu_top.sv */
`timescale 1ns/10ps

module alu_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  alu_pkg::decinst_t decinst,
    input  alu_pkg::word_t    rs1,
    input  alu_pkg::word_t    rs2,
    input  alu_pkg::word_t    imm,
    output logic              out_valid,
    input  logic              out_ready,
    output alu_pkg::word_t    rd,
    output logic              is_rd,
    output logic              cmp
);
    import alu_pkg::*;

    word_t shift_result;
    logic  load;

    alu_issue_if  iss_if ();
    shift_step_if step_if ();

    alu_issue issue_i (
        .decinst (decinst),
        .rs1     (rs1),
        .rs2     (rs2),
        .imm     (imm),
        .iss     (iss_if.src)
    );

    alu_ctrl_fsm ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .iss       (iss_if.dst),
        .step      (step_if.ctrl),
        .load      (load)
    );

    shift_counter counter_i (
        .clk   (clk),
        .reset (reset),
        .iss   (iss_if.dst),
        .step  (step_if.cnt)
    );

    alu_shifter shifter_i (
        .clk          (clk),
        .reset        (reset),
        .iss          (iss_if.dst),
        .step         (step_if.sh),
        .shift_result (shift_result)
    );

    alu_compute compute_i (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .iss          (iss_if.dst),
        .shift_result (shift_result),
        .rd           (rd),
        .is_rd        (is_rd),
        .cmp          (cmp)
    );

endmodule

/* alu_props.sv */
`timescale 1ns/10ps

module alu_props (
    input logic           clk,
    input logic           reset,
    input logic           in_valid,
    input logic           in_ready,
    input logic           out_valid,
    input logic           out_ready,
    input alu_pkg::word_t rd,
    input logic           is_rd,
    input logic           cmp
);
    int unsigned fails = 0;    // read by the testbench

    logic pending;    // accepted, result not yet taken

    always_ff @(posedge clk) begin
        if (!reset) begin
            pending <= 1'b0;
        end else if (in_valid && in_ready) begin
            pending <= 1'b1;
        end else if (out_valid && out_ready) begin
            pending <= 1'b0;
        end
    end

    // result held under back-pressure
    a_hold_stable: assert property (@(posedge clk) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable(rd) && $stable(is_rd) && $stable(cmp))
    else begin
        $error("result changed or dropped while out_ready was low");
        fails++;
    end

    // one operation in flight, and no result without one
    a_one_slot: assert property (@(posedge clk) disable iff (!reset)
        pending ? !in_ready : !out_valid)
    else begin
        $error("in_ready high with a result outstanding, or out_valid high with none");
        fails++;
    end

    a_reset_idle: assert property (@(posedge clk) !reset |=> !out_valid)
    else begin
        $error("out_valid high right after reset");
        fails++;
    end

endmodule

/* tb_alu.sv */
`timescale 1ns/10ps

module tb_alu;
    import alu_pkg::*;

    localparam int          NUM_OPS      = 600;
    localparam int          RESET_CYCLES = 8;
    localparam int          MAX_CYCLES   = 40 * NUM_OPS + RESET_CYCLES;
    localparam logic [31:0] SEED         = 32'h120f6db6;

    logic     clk;
    logic     reset;
    logic     in_valid;
    logic     in_ready;
    decinst_t decinst;
    word_t    rs1;
    word_t    rs2;
    word_t    imm;
    logic     out_valid;
    logic     out_ready;
    word_t    rd;
    logic     is_rd;
    logic     cmp;

    logic [31:0] lfsr;
    decinst_t    legal_codes [25];
    word_t       exp_rd_q [$];
    logic        exp_is_rd_q [$];
    logic        exp_cmp_q [$];
    word_t       e_rd;
    logic        e_is_rd;
    logic        e_cmp;
    logic        issued;
    int          sent;
    int          got;
    int          cycles;
    int          word_errs;
    int          flag_errs;
    int          other_errs;
    int          total;

    alu_top dut_i (.*);

    bind alu_top alu_props props_i (.*);

    always #4 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
        end
        return v;
    endfunction

    // expected rd, is_rd and cmp for one operation
    task automatic model_op(input decinst_t di, input word_t a, input word_t b,
                            input word_t i, output word_t m_rd, output logic m_is_rd,
                            output logic m_cmp);
        word_t  op2;
        shamt_t sh;
        op2 = (di inside {DI_ADDI, DI_ANDI, DI_XORI, DI_ORI, DI_SLTI, DI_SLTIU,
                          DI_SRLI, DI_SLLI, DI_SRAI}) ? i : b;
        sh      = op2[SHAMT_W-1:0];
        m_rd    = '0;
        m_is_rd = 1'b1;
        m_cmp   = 1'b0;
        case (di)
            DI_ADD, DI_ADDI:   m_rd = a + op2;
            DI_SUB:            m_rd = a - op2;
            DI_AND, DI_ANDI:   m_rd = a & op2;
            DI_XOR, DI_XORI:   m_rd = a ^ op2;
            DI_OR, DI_ORI:     m_rd = a | op2;
            DI_SLT, DI_SLTI:   m_rd = ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
            DI_SLTU, DI_SLTIU: m_rd = (a < op2) ? 32'd1 : 32'd0;
            DI_SRL, DI_SRLI:   m_rd = a >> sh;
            DI_SLL, DI_SLLI:   m_rd = a << sh;
            DI_SRA, DI_SRAI:   m_rd = word_t'($signed(a) >>> sh);
            DI_BEQ:  begin m_is_rd = 1'b0; m_cmp = (a == op2); end
            DI_BNE:  begin m_is_rd = 1'b0; m_cmp = (a != op2); end
            DI_BLT:  begin m_is_rd = 1'b0; m_cmp = ($signed(a) < $signed(op2)); end
            DI_BGE:  begin m_is_rd = 1'b0; m_cmp = ($signed(a) >= $signed(op2)); end
            DI_BLTU: begin m_is_rd = 1'b0; m_cmp = (a < op2); end
            DI_BGEU: begin m_is_rd = 1'b0; m_cmp = (a >= op2); end
            default: m_is_rd = 1'b0;    // illegal code
        endcase
    endtask

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("ERROR %0t %s: got %h, expected %h", $time, name, act, exp);
            word_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("ERROR %0t %s: got %b, expected %b", $time, name, act, exp);
            flag_errs++;
        end
    endtask

    task automatic new_op();
        logic [31:0] r;
        if (rand_bits(6) < 32'd50) begin
            decinst = legal_codes[rand_bits(5) % 25];
        end else begin
            decinst = decinst_t'(rand_bits(12));    // mostly illegal
        end
        rs1 = rand_bits(32);
        rs2 = rand_bits(32);
        r   = rand_bits(12);
        imm = {{20{r[11]}}, r[11:0]};
        case (rand_bits(3))
            3'd0: rs2 = rs1;
            3'd1: begin rs1 = 32'h8000_0000; rs2 = 32'h7fff_ffff; end
            3'd2: begin rs1 = 32'h7fff_ffff; rs2 = 32'h8000_0000; end
            3'd3: rs2 = 32'hffff_ffff;
            3'd4: rs2 = rand_bits(3);    // short shifts
            default: ;
        endcase
        in_valid = 1'b1;
    endtask

    task automatic take_result();
        if (exp_rd_q.size() == 0) begin
            $display("ERROR %0t: output transfer with no operation outstanding", $time);
            other_errs++;
        end else begin
            check_word("rd", rd, exp_rd_q.pop_front());
            check_flag("is_rd", is_rd, exp_is_rd_q.pop_front());
            check_flag("cmp", cmp, exp_cmp_q.pop_front());
        end
        got++;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycles, got, NUM_OPS);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b0;
        in_valid   = 1'b0;
        decinst    = '0;
        rs1        = '0;
        rs2        = '0;
        imm        = '0;
        out_ready  = 1'b0;
        lfsr       = SEED;
        issued     = 1'b0;
        sent       = 0;
        got        = 0;
        cycles     = 0;
        word_errs  = 0;
        flag_errs  = 0;
        other_errs = 0;
        legal_codes = '{DI_ADDI, DI_ADD, DI_SUB, DI_ANDI, DI_AND, DI_XORI, DI_XOR,
                        DI_ORI, DI_OR, DI_SLTI, DI_SLTIU, DI_SLT, DI_SLTU, DI_BEQ,
                        DI_BNE, DI_BLT, DI_BGE, DI_BLTU, DI_BGEU, DI_SRL, DI_SRLI,
                        DI_SLL, DI_SLLI, DI_SRA, DI_SRAI};
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);

        while (got < NUM_OPS) begin
            @(negedge clk);
            out_ready = (rand_bits(2) != 32'd0);    // random stalls
            if (out_valid && out_ready) begin
                take_result();
            end
            if (issued) begin
                in_valid = 1'b0;
                issued   = 1'b0;
            end
            if (!in_valid && sent < NUM_OPS && rand_bits(2) != 32'd0) begin
                new_op();
                sent++;
            end
            if (in_valid && in_ready) begin    // accepted on the next edge
                model_op(decinst, rs1, rs2, imm, e_rd, e_is_rd, e_cmp);
                exp_rd_q.push_back(e_rd);
                exp_is_rd_q.push_back(e_is_rd);
                exp_cmp_q.push_back(e_cmp);
                issued = 1'b1;
            end
        end

        if (exp_rd_q.size() != 0) begin
            $display("%0d accepted operations never returned a result", exp_rd_q.size());
            other_errs++;
        end
        total = word_errs + flag_errs + other_errs + dut_i.props_i.fails;
        $display("errors: rd %0d, flags %0d, other %0d, assertions %0d",
                 word_errs, flag_errs, other_errs, dut_i.props_i.fails);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
alu_pkg.sv
alu_issue_if.sv
shift_step_if.sv
alu_issue.sv
alu_ctrl_fsm.sv
shift_counter.sv
alu_shifter.sv
alu_compute.sv
alu_top.sv
alu_props.sv
tb_alu.sv
